/* vlog.f */
common/soc_bus_pkg.sv
arbiter/bus_arbiter.sv
logic/sram_slave.sv
logic/uart_tx_slave.sv
logic/clint_timer.sv
logic/mem_subsys_top.sv
verif/mem_subsys_chk.sv
verif/mem_subsys_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= mem_subsys_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test completed successfully
VFLAGS    ?= --binary --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verif/mem_subsys_tb.sv */
`timescale 1ns/1ps

module mem_subsys_tb;
    import soc_bus_pkg::*;

    localparam int          WORDS    = 256;
    localparam int          TIMEOUT  = 200;
    localparam logic [31:0] DEV_BASE = 32'hA000_0000;

    logic    clk_i = 1'b0;
    logic    rst_i;
    logic    fetch_ar_valid_i;
    ar_req_t fetch_ar_i;
    logic    fetch_ar_ready_o;
    logic    fetch_r_valid_o;
    r_rsp_t  fetch_r_o;
    logic    fetch_r_ready_i;
    logic    lsu_ar_valid_i;
    ar_req_t lsu_ar_i;
    logic    lsu_ar_ready_o;
    logic    lsu_r_valid_o;
    r_rsp_t  lsu_r_o;
    logic    lsu_r_ready_i;
    logic    lsu_w_valid_i;
    w_req_t  lsu_w_i;
    logic    lsu_w_ready_o;
    logic    lsu_b_valid_o;
    b_rsp_t  lsu_b_o;
    logic    lsu_b_ready_i;
    logic    uart_tx_valid_o;
    logic [7:0] uart_tx_byte_o;

    // reference model of the low 16 words
    logic [31:0] model_mem [16];
    logic [7:0]  tx_exp [$];
    int          seed = 19361;

    mem_subsys_top #(
        .MEM_WORDS (WORDS)
    ) dut_i (.*);

    always #2 clk_i = ~clk_i;

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else fail_run($sformatf("[FAIL] t=%0t %s: got %h, expected %h", $time, name, got, exp));
    endtask

    task automatic next_cycle(inout int cnt, input string what);
        @(posedge clk_i);
        #1;
        cnt++;
        if (cnt > TIMEOUT) begin
            fail_run({"timeout waiting for ", what});
        end
    endtask

    task automatic fetch_read(input logic [31:0] addr, output r_rsp_t rsp, output time t_rsp);
        int   cnt;
        logic done;
        cnt = 0;
        fetch_ar_valid_i = 1'b1;
        fetch_ar_i.addr  = addr;
        do begin
            @(negedge clk_i);
            // lsu takes a tie, so fetch only goes through with lsu quiet
            done = fetch_ar_ready_o && !lsu_ar_valid_i;
            next_cycle(cnt, "fetch AR handshake");
        end while (!done);
        fetch_ar_valid_i = 1'b0;
        cnt = 0;
        do begin
            @(negedge clk_i);
            done  = fetch_r_valid_o;
            rsp   = fetch_r_o;
            t_rsp = $time;
            next_cycle(cnt, "fetch R response");
        end while (!done);
    endtask

    task automatic lsu_read(input logic [31:0] addr, input int hold, output r_rsp_t rsp,
                            output time t_rsp);
        int   cnt;
        logic done;
        cnt = 0;
        lsu_r_ready_i  = (hold == 0);
        lsu_ar_valid_i = 1'b1;
        lsu_ar_i.addr  = addr;
        do begin
            @(negedge clk_i);
            done = lsu_ar_ready_o;
            next_cycle(cnt, "lsu AR handshake");
        end while (!done);
        lsu_ar_valid_i = 1'b0;
        cnt = 0;
        do begin
            @(negedge clk_i);
            done  = lsu_r_valid_o;
            rsp   = lsu_r_o;
            t_rsp = $time;
            next_cycle(cnt, "lsu R response");
        end while (!done);
        if (hold > 0) begin
            repeat (hold) begin
                @(posedge clk_i);
            end
            #1;
            lsu_r_ready_i = 1'b1;
            @(negedge clk_i);
            rsp = lsu_r_o;
            @(posedge clk_i);
            #1;
        end
    endtask

    task automatic lsu_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, output b_rsp_t rsp);
        int   cnt;
        logic done;
        cnt = 0;
        lsu_w_valid_i = 1'b1;
        lsu_w_i.addr  = addr;
        lsu_w_i.data  = data;
        lsu_w_i.strb  = strb;
        do begin
            @(negedge clk_i);
            done = lsu_w_ready_o;
            next_cycle(cnt, "lsu W handshake");
        end while (!done);
        lsu_w_valid_i = 1'b0;
        cnt = 0;
        do begin
            @(negedge clk_i);
            done = lsu_b_valid_o;
            rsp  = lsu_b_o;
            next_cycle(cnt, "lsu B response");
        end while (!done);
    endtask

    task automatic sram_write(input int idx, input logic [31:0] data, input logic [3:0] strb);
        b_rsp_t rsp;
        lsu_write(32'(idx * 4), data, strb, rsp);
        check_val("lsu_b_o.resp", 32'(rsp.resp), 32'(OKAY));
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                model_mem[idx][b*8 +: 8] = data[b*8 +: 8];
            end
        end
    endtask

    // even words through lsu, odd words through fetch
    task automatic check_sram();
        r_rsp_t rsp;
        time    t;
        for (int i = 0; i < 16; i++) begin
            if (i % 2 == 0) begin
                lsu_read(32'(i * 4), 0, rsp, t);
                check_val("lsu_r_o.data", rsp.data, model_mem[i]);
                check_val("lsu_r_o.resp", 32'(rsp.resp), 32'(OKAY));
            end else begin
                fetch_read(32'(i * 4), rsp, t);
                check_val("fetch_r_o.data", rsp.data, model_mem[i]);
                check_val("fetch_r_o.resp", 32'(rsp.resp), 32'(OKAY));
            end
        end
    endtask

    always @(negedge clk_i) begin
        if (!rst_i && uart_tx_valid_o) begin
            assert (tx_exp.size() > 0)
            else fail_run("UART sent a byte that no write asked for");
            check_val("uart_tx_byte_o", 32'(uart_tx_byte_o), 32'(tx_exp.pop_front()));
        end
    end

    always @(negedge clk_i) begin
        assert (!dut_i.u_arbiter.u_chk.chk_failed)
        else fail_run("a protocol assertion in the bus arbiter fired");
    end

    initial begin
        r_rsp_t      rsp_a;
        r_rsp_t      rsp_b;
        b_rsp_t      brsp;
        time         t_a;
        time         t_b;
        time         t_w;
        logic [31:0] data;
        logic [3:0]  strb;
        int          idx;

        rst_i            = 1'b1;
        fetch_ar_valid_i = 1'b0;
        fetch_ar_i       = '0;
        fetch_r_ready_i  = 1'b1;
        lsu_ar_valid_i   = 1'b0;
        lsu_ar_i         = '0;
        lsu_r_ready_i    = 1'b1;
        lsu_w_valid_i    = 1'b0;
        lsu_w_i          = '0;
        lsu_b_ready_i    = 1'b1;
        repeat (5) begin
            @(posedge clk_i);
        end
        #1;
        rst_i = 1'b0;

        // whole words first, then random strobed updates
        for (int i = 0; i < 16; i++) begin
            sram_write(i, $random(seed), 4'hF);
        end
        for (int i = 0; i < 24; i++) begin
            idx = $unsigned($random(seed)) % 16;
            sram_write(idx, $random(seed), 4'($random(seed)));
        end
        check_sram();

        fork
            lsu_read(32'h14, 0, rsp_a, t_a);
            fetch_read(32'h28, rsp_b, t_b);
        join
        assert (t_a < t_b)
        else fail_run("the lsu response did not arrive before the fetch response");
        check_val("lsu_r_o.data", rsp_a.data, model_mem[5]);
        check_val("fetch_r_o.data", rsp_b.data, model_mem[10]);

        for (int i = 0; i < 8; i++) begin
            data = $random(seed);
            strb = 4'($random(seed));
            if (strb[0]) begin
                tx_exp.push_back(data[7:0]);
            end
            lsu_write(DEV_BASE + 32'(i * 4), data, strb, brsp);
            check_val("lsu_b_o.resp", 32'(brsp.resp), 32'(OKAY));
        end
        check_val("uart bytes still expected", tx_exp.size(), 0);
        check_sram();

        // mtime upper word is still zero this early
        lsu_read(DEV_BASE, 0, rsp_a, t_a);
        lsu_read(DEV_BASE, 0, rsp_b, t_b);
        assert (rsp_b.data > rsp_a.data)
        else fail_run("mtime did not advance between two reads");
        check_val("lsu_r_o.resp", 32'(rsp_b.resp), 32'(OKAY));
        fetch_read(DEV_BASE + 32'h4, rsp_a, t_a);
        check_val("fetch_r_o.data", rsp_a.data, 32'h0);

        lsu_read(32'(WORDS * 4), 0, rsp_a, t_a);
        check_val("lsu_r_o.resp", 32'(rsp_a.resp), 32'(SLVERR));
        check_val("lsu_r_o.data", rsp_a.data, 32'h0);
        lsu_write(32'(WORDS * 4 + 8), 32'hDEAD_BEEF, 4'hF, brsp);
        check_val("lsu_b_o.resp", 32'(brsp.resp), 32'(SLVERR));

        // read held back while a write runs alongside
        data = $random(seed);
        fork
            begin
                lsu_read(32'hC, 10, rsp_a, t_a);
                t_b = $time;
            end
            begin
                lsu_write(32'h1C, data, 4'hF, brsp);
                t_w = $time;
            end
        join
        assert (t_w < t_b)
        else fail_run("the write did not finish while the read response was held");
        check_val("lsu_r_o.data", rsp_a.data, model_mem[3]);
        check_val("lsu_b_o.resp", 32'(brsp.resp), 32'(OKAY));
        model_mem[7] = data;
        check_sram();

        if (dut_i.u_arbiter.u_chk.chk_failed) begin
            fail_run("a protocol assertion in the bus arbiter fired");
        end else begin
            $display("Test completed successfully");
            $finish;
        end
    end

endmodule

/* verif/mem_subsys_chk.sv */
`timescale 1ns/1ps

module mem_subsys_chk (
    input logic                    clk_i,
    input logic                    rst_i,
    input logic                    fetch_r_valid_o,
    input logic                    fetch_r_ready_i,
    input soc_bus_pkg::r_rsp_t     fetch_r_o,
    input logic                    lsu_r_valid_o,
    input logic                    lsu_r_ready_i,
    input soc_bus_pkg::r_rsp_t     lsu_r_o,
    input logic                    lsu_b_valid_o,
    input logic                    lsu_b_ready_i,
    input soc_bus_pkg::b_rsp_t     lsu_b_o,
    input soc_bus_pkg::arb_state_e rd_state,
    input soc_bus_pkg::arb_state_e wr_state,
    input logic                    mem_ar_valid_o,
    input logic                    clint_ar_valid_o,
    input logic                    mem_w_valid_o,
    input logic                    uart_w_valid_o
);
    import soc_bus_pkg::*;

    logic excl_err  = 1'b0;
    logic fetch_err = 1'b0;
    logic lsu_err   = 1'b0;
    logic b_err     = 1'b0;
    logic idle_err  = 1'b0;
    logic chk_failed;

    assign chk_failed = excl_err | fetch_err | lsu_err | b_err | idle_err;

    // a single read machine answers one requester at a time
    assert property (@(posedge clk_i) disable iff (rst_i)
        !(fetch_r_valid_o && lsu_r_valid_o))
    else begin
        $error("fetch and lsu read valids high together");
        excl_err = 1'b1;
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        fetch_r_valid_o && !fetch_r_ready_i |=> fetch_r_valid_o && $stable(fetch_r_o))
    else begin
        $error("fetch read response dropped or changed before ready");
        fetch_err = 1'b1;
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        lsu_r_valid_o && !lsu_r_ready_i |=> lsu_r_valid_o && $stable(lsu_r_o))
    else begin
        $error("lsu read response dropped or changed before ready");
        lsu_err = 1'b1;
    end

    assert property (@(posedge clk_i) disable iff (rst_i)
        lsu_b_valid_o && !lsu_b_ready_i |=> lsu_b_valid_o && $stable(lsu_b_o))
    else begin
        $error("lsu write response dropped or changed before ready");
        b_err = 1'b1;
    end

    // slaves only see a request once a machine has left idle
    assert property (@(posedge clk_i) disable iff (rst_i)
        !(rd_state == ST_IDLE && (mem_ar_valid_o || clint_ar_valid_o)) &&
        !(wr_state == ST_IDLE && (mem_w_valid_o || uart_w_valid_o)))
    else begin
        $error("slave valid raised while its machine is idle");
        idle_err = 1'b1;
    end

endmodule

bind bus_arbiter mem_subsys_chk u_chk (.*);

/* logic/mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                 clk_i,
    input  logic                 rst_i,

    input  logic                 fetch_ar_valid_i,
    input  soc_bus_pkg::ar_req_t fetch_ar_i,
    output logic                 fetch_ar_ready_o,
    output logic                 fetch_r_valid_o,
    output soc_bus_pkg::r_rsp_t  fetch_r_o,
    input  logic                 fetch_r_ready_i,

    input  logic                 lsu_ar_valid_i,
    input  soc_bus_pkg::ar_req_t lsu_ar_i,
    output logic                 lsu_ar_ready_o,
    output logic                 lsu_r_valid_o,
    output soc_bus_pkg::r_rsp_t  lsu_r_o,
    input  logic                 lsu_r_ready_i,

    input  logic                 lsu_w_valid_i,
    input  soc_bus_pkg::w_req_t  lsu_w_i,
    output logic                 lsu_w_ready_o,
    output logic                 lsu_b_valid_o,
    output soc_bus_pkg::b_rsp_t  lsu_b_o,
    input  logic                 lsu_b_ready_i,

    output logic                 uart_tx_valid_o,
    output logic [7:0]           uart_tx_byte_o
);
    import soc_bus_pkg::*;

    ar_req_t slv_ar;
    w_req_t  slv_w;

    logic    mem_ar_valid;
    logic    mem_ar_ready;
    logic    mem_r_valid;
    r_rsp_t  mem_r;
    logic    mem_r_ready;
    logic    mem_w_valid;
    logic    mem_w_ready;
    logic    mem_b_valid;
    b_rsp_t  mem_b;
    logic    mem_b_ready;

    logic    clint_ar_valid;
    logic    clint_ar_ready;
    logic    clint_r_valid;
    r_rsp_t  clint_r;
    logic    clint_r_ready;

    logic    uart_w_valid;
    logic    uart_w_ready;
    logic    uart_b_valid;
    b_rsp_t  uart_b;
    logic    uart_b_ready;

    // requester ports share their names with the top level
    bus_arbiter u_arbiter (
        .*,
        .slv_ar_o         (slv_ar),
        .mem_ar_valid_o   (mem_ar_valid),
        .mem_ar_ready_i   (mem_ar_ready),
        .mem_r_valid_i    (mem_r_valid),
        .mem_r_i          (mem_r),
        .mem_r_ready_o    (mem_r_ready),
        .clint_ar_valid_o (clint_ar_valid),
        .clint_ar_ready_i (clint_ar_ready),
        .clint_r_valid_i  (clint_r_valid),
        .clint_r_i        (clint_r),
        .clint_r_ready_o  (clint_r_ready),
        .slv_w_o          (slv_w),
        .mem_w_valid_o    (mem_w_valid),
        .mem_w_ready_i    (mem_w_ready),
        .mem_b_valid_i    (mem_b_valid),
        .mem_b_i          (mem_b),
        .mem_b_ready_o    (mem_b_ready),
        .uart_w_valid_o   (uart_w_valid),
        .uart_w_ready_i   (uart_w_ready),
        .uart_b_valid_i   (uart_b_valid),
        .uart_b_i         (uart_b),
        .uart_b_ready_o   (uart_b_ready)
    );

    sram_slave #(
        .MEM_WORDS (MEM_WORDS)
    ) u_sram (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .ar_valid_i (mem_ar_valid),
        .ar_i       (slv_ar),
        .ar_ready_o (mem_ar_ready),
        .r_valid_o  (mem_r_valid),
        .r_o        (mem_r),
        .r_ready_i  (mem_r_ready),
        .w_valid_i  (mem_w_valid),
        .w_i        (slv_w),
        .w_ready_o  (mem_w_ready),
        .b_valid_o  (mem_b_valid),
        .b_o        (mem_b),
        .b_ready_i  (mem_b_ready)
    );

    uart_tx_slave u_uart (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .w_valid_i  (uart_w_valid),
        .w_i        (slv_w),
        .w_ready_o  (uart_w_ready),
        .b_valid_o  (uart_b_valid),
        .b_o        (uart_b),
        .b_ready_i  (uart_b_ready),
        .tx_valid_o (uart_tx_valid_o),
        .tx_byte_o  (uart_tx_byte_o)
    );

    clint_timer u_clint (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .ar_valid_i (clint_ar_valid),
        .ar_i       (slv_ar),
        .ar_ready_o (clint_ar_ready),
        .r_valid_o  (clint_r_valid),
        .r_o        (clint_r),
        .r_ready_i  (clint_r_ready)
    );

endmodule

/* logic/clint_timer.sv */
`timescale 1ns/1ps

module clint_timer (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 ar_valid_i,
    input  soc_bus_pkg::ar_req_t ar_i,
    output logic                 ar_ready_o,
    output logic                 r_valid_o,
    output soc_bus_pkg::r_rsp_t  r_o,
    input  logic                 r_ready_i
);
    import soc_bus_pkg::*;

    logic [63:0]       mtime;
    logic              ar_hs;
    logic              hi_sel;
    logic              r_valid_q;
    logic [DATA_W-1:0] r_data_q;

    assign ar_ready_o = !r_valid_q;
    assign ar_hs      = ar_valid_i && ar_ready_o;
    assign hi_sel     = ar_i.addr[$bits(CLINT_HI_OFS)-1:0] == CLINT_HI_OFS;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            mtime     <= '0;
            r_valid_q <= 1'b0;
        end else begin
            mtime <= mtime + 64'd1;
            if (ar_hs) begin
                r_valid_q <= 1'b1;
            end else if (r_ready_i) begin
                r_valid_q <= 1'b0;
            end
        end
    end

    // sampled at the handshake, later ticks don't move it
    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            r_data_q <= hi_sel ? mtime[63:32] : mtime[31:0];
        end
    end

    assign r_valid_o = r_valid_q;
    assign r_o.data  = r_data_q;
    assign r_o.resp  = OKAY;

endmodule

/* logic/uart_tx_slave.sv */
`timescale 1ns/1ps

module uart_tx_slave (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                w_valid_i,
    input  soc_bus_pkg::w_req_t w_i,
    output logic                w_ready_o,
    output logic                b_valid_o,
    output soc_bus_pkg::b_rsp_t b_o,
    input  logic                b_ready_i,
    output logic                tx_valid_o,
    output logic [7:0]          tx_byte_o
);
    import soc_bus_pkg::*;

    logic       w_hs;
    logic       b_valid_q;
    logic       tx_valid_q;
    logic [7:0] tx_byte_q;

    // no new write until the previous response is taken
    assign w_ready_o = !b_valid_q;
    assign w_hs      = w_valid_i && w_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            b_valid_q  <= 1'b0;
            tx_valid_q <= 1'b0;
        end else begin
            // single cycle strobe only when lane 0 is written
            tx_valid_q <= w_hs && w_i.strb[0];
            if (w_hs) begin
                b_valid_q <= 1'b1;
            end else if (b_ready_i) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (w_hs) begin
            tx_byte_q <= w_i.data[7:0];
        end
    end

    assign tx_valid_o = tx_valid_q;
    assign tx_byte_o  = tx_byte_q;
    assign b_valid_o  = b_valid_q;
    assign b_o.resp   = OKAY;

endmodule

/* logic/sram_slave.sv */
`timescale 1ns/1ps

module sram_slave #(
    parameter int MEM_WORDS = 1024
) (
    input  logic                 clk_i,
    input  logic                 rst_i,
    input  logic                 ar_valid_i,
    input  soc_bus_pkg::ar_req_t ar_i,
    output logic                 ar_ready_o,
    output logic                 r_valid_o,
    output soc_bus_pkg::r_rsp_t  r_o,
    input  logic                 r_ready_i,
    input  logic                 w_valid_i,
    input  soc_bus_pkg::w_req_t  w_i,
    output logic                 w_ready_o,
    output logic                 b_valid_o,
    output soc_bus_pkg::b_rsp_t  b_o,
    input  logic                 b_ready_i
);
    import soc_bus_pkg::*;

    localparam int IDX_W  = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int OFS_W  = $clog2(STRB_W);
    localparam int WIDX_W = ADDR_W - OFS_W;
    localparam logic [WIDX_W-1:0] WORD_LIMIT = WIDX_W'(MEM_WORDS);

    logic [DATA_W-1:0] mem [MEM_WORDS];

    logic [WIDX_W-1:0] rd_widx;
    logic [WIDX_W-1:0] wr_widx;
    logic              rd_in_range;
    logic              wr_in_range;
    logic              ar_hs;
    logic              w_hs;
    logic              r_valid_q;
    logic              b_valid_q;
    r_rsp_t            r_q;
    b_rsp_t            b_q;

    assign rd_widx     = ar_i.addr[ADDR_W-1:OFS_W];
    assign wr_widx     = w_i.addr[ADDR_W-1:OFS_W];
    assign rd_in_range = rd_widx < WORD_LIMIT;
    assign wr_in_range = wr_widx < WORD_LIMIT;

    assign ar_ready_o = !r_valid_q;
    assign w_ready_o  = !b_valid_q;
    assign ar_hs      = ar_valid_i && ar_ready_o;
    assign w_hs       = w_valid_i && w_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (ar_hs) begin
                r_valid_q <= 1'b1;
            end else if (r_ready_i) begin
                r_valid_q <= 1'b0;
            end
            if (w_hs) begin
                b_valid_q <= 1'b1;
            end else if (b_ready_i) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    // out of range words are never touched
    always_ff @(posedge clk_i) begin
        if (w_hs && wr_in_range) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (w_i.strb[i]) begin
                    mem[wr_widx[IDX_W-1:0]][i*8 +: 8] <= w_i.data[i*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (ar_hs) begin
            r_q.data <= rd_in_range ? mem[rd_widx[IDX_W-1:0]] : '0;
            r_q.resp <= rd_in_range ? OKAY : SLVERR;
        end
        if (w_hs) begin
            b_q.resp <= wr_in_range ? OKAY : SLVERR;
        end
    end

    assign r_valid_o = r_valid_q;
    assign r_o       = r_q;
    assign b_valid_o = b_valid_q;
    assign b_o       = b_q;

endmodule

/* arbiter/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                 clk_i,
    input  logic                 rst_i,

    input  logic                 fetch_ar_valid_i,
    input  soc_bus_pkg::ar_req_t fetch_ar_i,
    output logic                 fetch_ar_ready_o,
    output logic                 fetch_r_valid_o,
    output soc_bus_pkg::r_rsp_t  fetch_r_o,
    input  logic                 fetch_r_ready_i,

    input  logic                 lsu_ar_valid_i,
    input  soc_bus_pkg::ar_req_t lsu_ar_i,
    output logic                 lsu_ar_ready_o,
    output logic                 lsu_r_valid_o,
    output soc_bus_pkg::r_rsp_t  lsu_r_o,
    input  logic                 lsu_r_ready_i,

    input  logic                 lsu_w_valid_i,
    input  soc_bus_pkg::w_req_t  lsu_w_i,
    output logic                 lsu_w_ready_o,
    output logic                 lsu_b_valid_o,
    output soc_bus_pkg::b_rsp_t  lsu_b_o,
    input  logic                 lsu_b_ready_i,

    output soc_bus_pkg::ar_req_t slv_ar_o,
    output logic                 mem_ar_valid_o,
    input  logic                 mem_ar_ready_i,
    input  logic                 mem_r_valid_i,
    input  soc_bus_pkg::r_rsp_t  mem_r_i,
    output logic                 mem_r_ready_o,
    output logic                 clint_ar_valid_o,
    input  logic                 clint_ar_ready_i,
    input  logic                 clint_r_valid_i,
    input  soc_bus_pkg::r_rsp_t  clint_r_i,
    output logic                 clint_r_ready_o,

    output soc_bus_pkg::w_req_t  slv_w_o,
    output logic                 mem_w_valid_o,
    input  logic                 mem_w_ready_i,
    input  logic                 mem_b_valid_i,
    input  soc_bus_pkg::b_rsp_t  mem_b_i,
    output logic                 mem_b_ready_o,
    output logic                 uart_w_valid_o,
    input  logic                 uart_w_ready_i,
    input  logic                 uart_b_valid_i,
    input  soc_bus_pkg::b_rsp_t  uart_b_i,
    output logic                 uart_b_ready_o
);
    import soc_bus_pkg::*;

    function automatic logic in_dev_region(input logic [ADDR_W-1:0] addr);
        return addr[ADDR_W-1 -: $bits(DEV_NIBBLE)] == DEV_NIBBLE;
    endfunction

    arb_state_e rd_state;
    req_src_e   rd_src;
    logic       rd_dev;
    ar_req_t    rd_req;
    r_rsp_t     rd_rsp;
    logic       rd_slv_ready;
    logic       rd_slv_valid;
    logic       rd_req_ready;

    arb_state_e wr_state;
    logic       wr_dev;
    w_req_t     wr_req;
    b_rsp_t     wr_rsp;
    logic       wr_slv_ready;
    logic       wr_slv_valid;

    // handshakes of the selected read slave and requester
    assign rd_slv_ready = rd_dev ? clint_ar_ready_i : mem_ar_ready_i;
    assign rd_slv_valid = rd_dev ? clint_r_valid_i : mem_r_valid_i;
    assign rd_req_ready = (rd_src == SRC_LSU) ? lsu_r_ready_i : fetch_r_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_state <= ST_IDLE;
        end else begin
            case (rd_state)
                ST_IDLE: begin
                    if (lsu_ar_valid_i || fetch_ar_valid_i) begin
                        rd_state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (rd_slv_ready) begin
                        rd_state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (rd_slv_valid) begin
                        rd_state <= ST_RESP;
                    end
                end
                default: begin
                    if (rd_req_ready) begin
                        rd_state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // lsu wins a tie, fetch keeps its valid up
    always_ff @(posedge clk_i) begin
        if (rd_state == ST_IDLE) begin
            if (lsu_ar_valid_i) begin
                rd_src <= SRC_LSU;
                rd_req <= lsu_ar_i;
                rd_dev <= in_dev_region(lsu_ar_i.addr);
            end else if (fetch_ar_valid_i) begin
                rd_src <= SRC_FETCH;
                rd_req <= fetch_ar_i;
                rd_dev <= in_dev_region(fetch_ar_i.addr);
            end
        end
        // data and resp captured together
        if (rd_state == ST_WAIT && rd_slv_valid) begin
            rd_rsp <= rd_dev ? clint_r_i : mem_r_i;
        end
    end

    assign fetch_ar_ready_o = rd_state == ST_IDLE;
    assign lsu_ar_ready_o   = rd_state == ST_IDLE;
    assign fetch_r_valid_o  = rd_state == ST_RESP && rd_src == SRC_FETCH;
    assign lsu_r_valid_o    = rd_state == ST_RESP && rd_src == SRC_LSU;
    assign fetch_r_o        = rd_rsp;
    assign lsu_r_o          = rd_rsp;

    assign slv_ar_o         = rd_req;
    assign mem_ar_valid_o   = rd_state == ST_ISSUE && !rd_dev;
    assign clint_ar_valid_o = rd_state == ST_ISSUE && rd_dev;
    assign mem_r_ready_o    = rd_state == ST_WAIT && !rd_dev;
    assign clint_r_ready_o  = rd_state == ST_WAIT && rd_dev;

    // writes come from the lsu only
    assign wr_slv_ready = wr_dev ? uart_w_ready_i : mem_w_ready_i;
    assign wr_slv_valid = wr_dev ? uart_b_valid_i : mem_b_valid_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            wr_state <= ST_IDLE;
        end else begin
            case (wr_state)
                ST_IDLE: begin
                    if (lsu_w_valid_i) begin
                        wr_state <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    if (wr_slv_ready) begin
                        wr_state <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (wr_slv_valid) begin
                        wr_state <= ST_RESP;
                    end
                end
                default: begin
                    if (lsu_b_ready_i) begin
                        wr_state <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr_state == ST_IDLE && lsu_w_valid_i) begin
            wr_req <= lsu_w_i;
            wr_dev <= in_dev_region(lsu_w_i.addr);
        end
        if (wr_state == ST_WAIT && wr_slv_valid) begin
            wr_rsp <= wr_dev ? uart_b_i : mem_b_i;
        end
    end

    assign lsu_w_ready_o  = wr_state == ST_IDLE;
    assign lsu_b_valid_o  = wr_state == ST_RESP;
    assign lsu_b_o        = wr_rsp;

    assign slv_w_o        = wr_req;
    assign mem_w_valid_o  = wr_state == ST_ISSUE && !wr_dev;
    assign uart_w_valid_o = wr_state == ST_ISSUE && wr_dev;
    assign mem_b_ready_o  = wr_state == ST_WAIT && !wr_dev;
    assign uart_b_ready_o = wr_state == ST_WAIT && wr_dev;

endmodule

/* common/soc_bus_pkg.sv */
package soc_bus_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // address bits 31:28 of the device region
    localparam logic [3:0] DEV_NIBBLE = 4'hA;

    // byte offset of the upper mtime word
    localparam logic [3:0] CLINT_HI_OFS = 4'h4;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,
        ST_ISSUE = 2'b01,
        ST_WAIT  = 2'b10,
        ST_RESP  = 2'b11
    } arb_state_e;

    typedef enum logic {
        SRC_FETCH = 1'b0,
        SRC_LSU   = 1'b1
    } req_src_e;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
    } ar_req_t;

    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [STRB_W-1:0] strb;
    } w_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] data;
        resp_e             resp;
    } r_rsp_t;

    typedef struct packed {
        resp_e resp;
    } b_rsp_t;

endpackage
